//--- bench/fxRenameTableTb.sv
`include "fxRename_params.svh"

module fxRenameTableTb;
    timeunit 1ns;
    timeprecision 1ps;
    import fxRenamePkg::*;

    localparam int CLOCK_PERIOD = 4;
    localparam int DIRECTED_GROUPS = 19;
    localparam int RANDOM_GROUPS = 200;
    localparam int TEST_COUNT = 6;
    // each group may carry an idle gap, each test drains for about a dozen cycles
    localparam int WATCHDOG_NS = ((DIRECTED_GROUPS + RANDOM_GROUPS) * 2 + TEST_COUNT * 12 + 3)
        * CLOCK_PERIOD + 400;

    logic clock;
    logic reset;
    logic enable;
    laneCount_t numInst;
    robTag_t [`RAT_LANES-1:0] robEntry;
    opCode_t [`RAT_LANES-1:0] opCode;
    operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operand;
    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandEn;
    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandIsReg;
    operandKind_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandKind;

    logic validOut;
    laneCount_t numInstOut;
    opCode_t [`RAT_LANES-1:0] opCodeOut;
    operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandOut;
    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandEnOut;
    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandIsRegOut;
    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] mappedOut;

    int errorCount;
    int resultCount;
    int pushCount;
    int groupsSent;
    int testsRun;
    int testsFailed;
    int testErrorBase;
    logic [31:0] lcgState = 32'h7649;

    fxRenameTable uut
    (
        .clock_i(clock),
        .reset_i(reset),
        .enable_i(enable),
        .numInst_i(numInst),
        .robEntry_i(robEntry),
        .opCode_i(opCode),
        .operand_i(operand),
        .operandEn_i(operandEn),
        .operandIsReg_i(operandIsReg),
        .operandKind_i(operandKind),
        .validOut_o(validOut),
        .numInst_o(numInstOut),
        .opCode_o(opCodeOut),
        .operand_o(operandOut),
        .operandEn_o(operandEnOut),
        .operandIsReg_o(operandIsRegOut),
        .mapped_o(mappedOut)
    );

    renameScoreboard scoreboard
    (
        .clock_i(clock),
        .reset_i(reset),
        .enable_i(enable),
        .numInst_i(numInst),
        .robEntry_i(robEntry),
        .opCode_i(opCode),
        .operand_i(operand),
        .operandEn_i(operandEn),
        .operandIsReg_i(operandIsReg),
        .operandKind_i(operandKind),
        .validOut_i(validOut),
        .numInstOut_i(numInstOut),
        .opCodeOut_i(opCodeOut),
        .operandOut_i(operandOut),
        .operandEnOut_i(operandEnOut),
        .operandIsRegOut_i(operandIsRegOut),
        .mappedOut_i(mappedOut),
        .errorCount_o(errorCount),
        .resultCount_o(resultCount),
        .pushCount_o(pushCount)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // two steps per call, only the upper halves are kept
    function automatic logic [31:0] nextRandom();
        logic [15:0] high;
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        high = lcgState[31:16];
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {high, lcgState[31:16]};
    endfunction

    task automatic startCycle();
        @(posedge clock);
        #1;
    endtask

    task automatic clearFields();
        enable = 1'b0;
        numInst = '0;
        robEntry = '0;
        opCode = '0;
        operand = '0;
        operandEn = '0;
        operandIsReg = '0;
        for (int l = 0; l < `RAT_LANES; l++)
        begin
            for (int o = 0; o < `RAT_OPERANDS; o++)
                operandKind[l][o] = kindRead;
        end
    endtask

    task automatic idleCycle();
        startCycle();
        clearFields();
    endtask

    task automatic beginGroup(int count, robTag_t rob0, robTag_t rob1);
        startCycle();
        clearFields();
        enable = 1'b1;
        numInst = laneCount_t'(count);
        robEntry[0] = rob0;
        robEntry[1] = rob1;
        opCode[0] = opCode_t'(nextRandom());  // opcode only rides along
        opCode[1] = opCode_t'(nextRandom());
        groupsSent++;
    endtask

    task automatic putOperand(int lane, int slot, logic en, logic isReg, operandKind_t kind,
        operand_t value);
        operandEn[lane][slot] = en;
        operandIsReg[lane][slot] = isReg;
        operandKind[lane][slot] = kind;
        operand[lane][slot] = value;
    endtask

    task automatic putRegister(int lane, int slot, operandKind_t kind, int regNum);
        putOperand(lane, slot, 1'b1, 1'b1, kind, operand_t'(regNum));
    endtask

    task automatic randomOperand(int lane, int slot);
        logic [31:0] r;
        operand_t value;
        operandKind_t kind;
        r = nextRandom();
        value = {nextRandom(), nextRandom()};
        kind = operandKind_t'(r[5:4]);
        if (r[3:2] != 2'b00)
            value[`RAT_REG_W-1:0] = regIndex_t'(r[10:8]);  // registers 0 to 7 so groups collide
        else if (kind == kindWrite || kind == kindReadWrite)
            kind = kindRead;  // an immediate is never renamed
        putOperand(lane, slot, r[1:0] != 2'b00, r[3:2] != 2'b00, kind, value);
    endtask

    task automatic finishTest(string name);
        int errors;
        idleCycle();
        while (pushCount != resultCount)
            startCycle();
        repeat (2) startCycle();  // last result still being compared
        errors = errorCount - testErrorBase;
        testsRun++;
        if (errors != 0)
            testsFailed++;
        $display("test %0d %s: %s, %0d errors", testsRun, name,
            (errors == 0) ? "ok" : "failed", errors);
        testErrorBase = errorCount;
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t with results still outstanding", $time);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        reset = 1'b1;
        clearFields();
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        repeat (3) idleCycle();  // output must stay quiet here

        for (int g = 0; g < 6; g++)
        begin
            beginGroup(1, 7'h01, 7'h02);
            for (int s = 0; s < 2 * `RAT_OPERANDS; s++)
                putRegister(s / `RAT_OPERANDS, s % `RAT_OPERANDS,
                    (s % 2 == 1) ? kindReserved : kindRead, (g * 6 + s) % 32);
        end
        finishTest("reset state");

        beginGroup(0, 7'h11, 7'h00);
        putRegister(0, 0, kindWrite, 3);
        putRegister(0, 1, kindRead, 3);  // own write not visible yet
        putRegister(0, 2, kindReadWrite, 4);
        beginGroup(0, 7'h12, 7'h00);
        putRegister(0, 0, kindRead, 3);
        putRegister(0, 1, kindReadWrite, 4);
        putRegister(0, 2, kindWrite, 3);
        beginGroup(0, 7'h13, 7'h00);
        putRegister(0, 0, kindRead, 3);
        putRegister(0, 1, kindRead, 4);
        finishTest("write then read");

        beginGroup(1, 7'h14, 7'h15);
        putOperand(0, 0, 1'b1, 1'b0, kindRead, 64'hdead_beef_0123_4567);
        putOperand(0, 1, 1'b0, 1'b1, kindWrite, 64'h5);
        putOperand(0, 2, 1'b1, 1'b0, kindReserved, '1);
        putOperand(1, 0, 1'b0, 1'b1, kindReadWrite, 64'h5);
        putOperand(1, 1, 1'b1, 1'b0, kindRead, 64'h8000_0000_0000_0001);
        putRegister(1, 2, kindRead, 5);
        beginGroup(0, 7'h16, 7'h00);
        putRegister(0, 0, kindRead, 5);  // disabled writes left it unmapped
        finishTest("pass-through and disabled");

        beginGroup(1, 7'h20, 7'h21);
        putRegister(0, 0, kindWrite, 7);
        putRegister(0, 1, kindRead, 7);
        putRegister(1, 0, kindRead, 7);  // sees lane 0 in the same group
        putRegister(1, 1, kindWrite, 7);
        putRegister(1, 2, kindRead, 8);
        beginGroup(0, 7'h22, 7'h23);
        putRegister(0, 0, kindRead, 7);
        putRegister(1, 0, kindWrite, 20);  // lane beyond the count
        putRegister(1, 1, kindReadWrite, 21);
        beginGroup(1, 7'h24, 7'h25);
        putRegister(0, 0, kindRead, 20);
        putRegister(0, 1, kindRead, 21);
        putRegister(1, 0, kindRead, 20);
        beginGroup(1, 7'h26, 7'h27);
        putRegister(0, 0, kindReadWrite, 9);
        putRegister(1, 0, kindReadWrite, 9);
        finishTest("same-group dependency");

        beginGroup(0, 7'h30, 7'h00);
        putRegister(0, 0, kindWrite, 2);
        beginGroup(0, 7'h31, 7'h00);
        putRegister(0, 0, kindRead, 2);
        putRegister(0, 1, kindWrite, 2);
        beginGroup(1, 7'h32, 7'h33);
        putRegister(0, 0, kindRead, 2);
        putRegister(1, 0, kindReadWrite, 2);
        beginGroup(0, 7'h34, 7'h00);
        putRegister(0, 0, kindRead, 2);
        finishTest("back-to-back groups");

        for (int g = 0; g < RANDOM_GROUPS; g++)
        begin
            if (nextRandom() % 4 == 0)
                idleCycle();
            beginGroup(int'(nextRandom() % 2), robTag_t'(nextRandom()), robTag_t'(nextRandom()));
            for (int l = 0; l < `RAT_LANES; l++)
            begin
                for (int o = 0; o < `RAT_OPERANDS; o++)
                    randomOperand(l, o);
            end
        end
        finishTest("random run");

        if (resultCount != groupsSent)
            $display("%0d groups were sent but %0d results were checked", groupsSent,
                resultCount);
        $display("tests %0d, failed %0d, results checked %0d, errors %0d", testsRun,
            testsFailed, resultCount, errorCount);
        if (testsFailed == 0 && errorCount == 0 && resultCount == groupsSent)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- bench/renameScoreboard.sv
`include "fxRename_params.svh"

module renameScoreboard
(
    input  logic clock_i,
    input  logic reset_i,
    input  logic enable_i,
    input  fxRenamePkg::laneCount_t numInst_i,
    input  fxRenamePkg::robTag_t [`RAT_LANES-1:0] robEntry_i,
    input  fxRenamePkg::opCode_t [`RAT_LANES-1:0] opCode_i,
    input  fxRenamePkg::operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operand_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandEn_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandIsReg_i,
    input  fxRenamePkg::operandKind_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandKind_i,
    input  logic validOut_i,
    input  fxRenamePkg::laneCount_t numInstOut_i,
    input  fxRenamePkg::opCode_t [`RAT_LANES-1:0] opCodeOut_i,
    input  fxRenamePkg::operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandOut_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandEnOut_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandIsRegOut_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] mappedOut_i,
    output int errorCount_o,
    output int resultCount_o,
    output int pushCount_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import fxRenamePkg::*;

    typedef logic [`RAT_OPERANDS*`RAT_OPERAND_W-1:0] wideValue_t;  // widest printed field

    typedef struct packed
    {
        int dueCycle;  // cycle whose output edge carries the result
        laneCount_t numInst;
        opCode_t [`RAT_LANES-1:0] opCode;
        operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operand;
        logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] en;
        logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] isReg;
        logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] mapped;
    } expResult_t;

    robTag_t shadowTag [`RAT_REGS];
    logic shadowMapped [`RAT_REGS];
    expResult_t expQ [$];
    expResult_t expNow;  // result due on the coming edge
    logic expValid = 1'b0;
    int cycleCount;

    task automatic reportMismatch(string signal, wideValue_t got, wideValue_t expected);
        errorCount_o++;
        $display("MISMATCH at %0t: %s got %0h expected %0h", $time, signal, got, expected);
    endtask

    // lanes in order, each reads before its own writes land
    task automatic predictGroup();
        expResult_t e;
        regIndex_t idx;
        e = '0;
        e.dueCycle = cycleCount + 1;
        e.numInst = numInst_i;
        e.opCode = opCode_i;
        for (int l = 0; l < `RAT_LANES; l++)
        begin
            if (l <= int'(numInst_i))
            begin
                for (int o = 0; o < `RAT_OPERANDS; o++)
                begin
                    idx = operand_i[l][o][`RAT_REG_W-1:0];
                    e.en[l][o] = operandEn_i[l][o];
                    e.isReg[l][o] = operandEn_i[l][o] && operandIsReg_i[l][o];
                    if (operandEn_i[l][o] && !operandIsReg_i[l][o])
                        e.operand[l][o] = operand_i[l][o];
                    else if (e.isReg[l][o] && shadowMapped[idx])
                    begin
                        e.operand[l][o] = operand_t'(shadowTag[idx]);
                        e.mapped[l][o] = 1'b1;
                    end
                    else if (e.isReg[l][o])
                        e.operand[l][o] = operand_t'(idx);  // architectural copy
                end
                for (int o = 0; o < `RAT_OPERANDS; o++)
                begin
                    idx = operand_i[l][o][`RAT_REG_W-1:0];
                    if (operandEn_i[l][o] && operandIsReg_i[l][o]
                        && (operandKind_i[l][o] == kindWrite
                        || operandKind_i[l][o] == kindReadWrite))
                    begin
                        shadowTag[idx] = robEntry_i[l];
                        shadowMapped[idx] = 1'b1;
                    end
                end
            end
        end
        expQ.push_back(e);
        pushCount_o++;
    endtask

    always @(posedge clock_i)
    begin
        if (reset_i)
        begin
            cycleCount = 0;
            expQ.delete();
            for (int r = 0; r < `RAT_REGS; r++)
                shadowMapped[r] = 1'b0;
        end
        else
        begin
            cycleCount++;
            if (enable_i)
                predictGroup();
        end
    end

    // outputs are settled mid-cycle, line up the result due next edge
    always @(negedge clock_i)
    begin
        expValid = 1'b0;
        if (!reset_i && expQ.size() > 0 && expQ[0].dueCycle == cycleCount)
        begin
            expNow = expQ.pop_front();
            expValid = 1'b1;
            resultCount_o++;
        end
    end

    validMatches: assert property (@(posedge clock_i) disable iff (reset_i)
        validOut_i == expValid)
        else reportMismatch("validOut_o", wideValue_t'($sampled(validOut_i)),
            wideValue_t'(expValid));

    countMatches: assert property (@(posedge clock_i) disable iff (reset_i)
        (validOut_i && expValid) |-> numInstOut_i == expNow.numInst)
        else reportMismatch("numInst_o", wideValue_t'($sampled(numInstOut_i)),
            wideValue_t'(expNow.numInst));

    for (genvar l = 0; l < `RAT_LANES; l++)
    begin : laneCheck
        logic laneLive;  // lanes past the count carry stale fields
        assign laneLive = validOut_i && expValid && (l <= int'(expNow.numInst));

        opCodeMatches: assert property (@(posedge clock_i) disable iff (reset_i)
            laneLive |-> opCodeOut_i[l] == expNow.opCode[l])
            else reportMismatch($sformatf("opCode_o[%0d]", l),
                wideValue_t'($sampled(opCodeOut_i[l])), wideValue_t'(expNow.opCode[l]));

        operandMatches: assert property (@(posedge clock_i) disable iff (reset_i)
            laneLive |-> operandOut_i[l] == expNow.operand[l])
            else reportMismatch($sformatf("operand_o[%0d]", l),
                wideValue_t'($sampled(operandOut_i[l])), wideValue_t'(expNow.operand[l]));

        enableMatches: assert property (@(posedge clock_i) disable iff (reset_i)
            laneLive |-> operandEnOut_i[l] == expNow.en[l])
            else reportMismatch($sformatf("operandEn_o[%0d]", l),
                wideValue_t'($sampled(operandEnOut_i[l])), wideValue_t'(expNow.en[l]));

        isRegMatches: assert property (@(posedge clock_i) disable iff (reset_i)
            laneLive |-> operandIsRegOut_i[l] == expNow.isReg[l])
            else reportMismatch($sformatf("operandIsReg_o[%0d]", l),
                wideValue_t'($sampled(operandIsRegOut_i[l])), wideValue_t'(expNow.isReg[l]));

        mappedMatches: assert property (@(posedge clock_i) disable iff (reset_i)
            laneLive |-> mappedOut_i[l] == expNow.mapped[l])
            else reportMismatch($sformatf("mapped_o[%0d]", l),
                wideValue_t'($sampled(mappedOut_i[l])), wideValue_t'(expNow.mapped[l]));
    end

endmodule

//--- fxRenameTable.f
+incdir+verilog
verilog/fxRenamePkg.sv
verilog/ratGroupLatch.sv
verilog/ratMapTable.sv
verilog/ratDependencyCheck.sv
verilog/fxRenameTable.sv
bench/renameScoreboard.sv
bench/fxRenameTableTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module fxRenameTableTb \
    -f fxRenameTable.f \
    -o fxRenameSim \
    && ./obj_dir/fxRenameSim | tee /dev/stderr | grep -F "ALL CHECKS PASSED" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- verilog/fxRenamePkg.sv
`include "fxRename_params.svh"

package fxRenamePkg;

    // operand value, or a register number in its low bits
    typedef logic [`RAT_OPERAND_W-1:0] operand_t;

    typedef logic [`RAT_TAG_W-1:0] robTag_t;  // reorder buffer entry
    typedef logic [`RAT_REG_W-1:0] regIndex_t;
    typedef logic [`RAT_OPCODE_W-1:0] opCode_t;

    // instructions in the group minus one
    typedef logic [$clog2(`RAT_LANES)-1:0] laneCount_t;

    // access kind of a register operand, 00 behaves as a read
    typedef enum logic [1:0]
    {
        kindReserved = 2'b00,
        kindRead = 2'b01,
        kindWrite = 2'b10,
        kindReadWrite = 2'b11
    } operandKind_t;

endpackage

//--- verilog/fxRenameTable.sv
`include "fxRename_params.svh"

module fxRenameTable
(
    input  logic clock_i,
    input  logic reset_i,
    input  logic enable_i,
    input  fxRenamePkg::laneCount_t numInst_i,
    input  fxRenamePkg::robTag_t [`RAT_LANES-1:0] robEntry_i,
    input  fxRenamePkg::opCode_t [`RAT_LANES-1:0] opCode_i,
    input  fxRenamePkg::operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operand_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandEn_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandIsReg_i,
    input  fxRenamePkg::operandKind_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandKind_i,
    output logic validOut_o,
    output fxRenamePkg::laneCount_t numInst_o,
    output fxRenamePkg::opCode_t [`RAT_LANES-1:0] opCode_o,
    output fxRenamePkg::operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operand_o,
    output logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandEn_o,
    output logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandIsReg_o,
    output logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] mapped_o
);
    import fxRenamePkg::*;

    // stage 1 holding registers
    logic stageValid;
    logic [`RAT_LANES-1:0] laneLive;
    laneCount_t heldNumInst;
    robTag_t [`RAT_LANES-1:0] heldRobEntry;
    opCode_t [`RAT_LANES-1:0] heldOpCode;
    operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] heldOperand;
    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] heldEn;
    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] heldIsReg;
    operandKind_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] heldKind;

    // table ports
    regIndex_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] readIndex;
    robTag_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] readTag;
    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] readMapped;
    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] writeEn;
    regIndex_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] writeIndex;
    robTag_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] writeTag;

    operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] resolved;
    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] resolvedMapped;

    ratGroupLatch groupLatch
    (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .enable_i(enable_i),
        .numInst_i(numInst_i),
        .robEntry_i(robEntry_i),
        .opCode_i(opCode_i),
        .operand_i(operand_i),
        .operandEn_i(operandEn_i),
        .operandIsReg_i(operandIsReg_i),
        .operandKind_i(operandKind_i),
        .stageValid_o(stageValid),
        .laneLive_o(laneLive),
        .numInst_o(heldNumInst),
        .robEntry_o(heldRobEntry),
        .opCode_o(heldOpCode),
        .operand_o(heldOperand),
        .operandEn_o(heldEn),
        .operandIsReg_o(heldIsReg),
        .operandKind_o(heldKind)
    );

    ratDependencyCheck depCheck
    (
        .stageValid_i(stageValid),
        .laneLive_i(laneLive),
        .robEntry_i(heldRobEntry),
        .operand_i(heldOperand),
        .operandEn_i(heldEn),
        .operandIsReg_i(heldIsReg),
        .operandKind_i(heldKind),
        .readIndex_o(readIndex),
        .readTag_i(readTag),
        .readMapped_i(readMapped),
        .writeEn_o(writeEn),
        .writeIndex_o(writeIndex),
        .writeTag_o(writeTag),
        .resolved_o(resolved),
        .resolvedMapped_o(resolvedMapped)
    );

    ratMapTable mapTable
    (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .readIndex_i(readIndex),
        .readTag_o(readTag),
        .readMapped_o(readMapped),
        .writeEn_i(writeEn),
        .writeIndex_i(writeIndex),
        .writeTag_i(writeTag)
    );

    always_ff @(posedge clock_i)
    begin
        if (reset_i)
            validOut_o <= 1'b0;
        else
            validOut_o <= stageValid;
    end

    // stage 2 result, held while idle
    always_ff @(posedge clock_i)
    begin
        if (stageValid)
        begin
            numInst_o <= heldNumInst;
            opCode_o <= heldOpCode;  // opcode rides along untouched
            operand_o <= resolved;
            operandEn_o <= heldEn;
            operandIsReg_o <= heldEn & heldIsReg;
            mapped_o <= resolvedMapped;
        end
    end

endmodule

//--- verilog/fxRename_params.svh
`ifndef FXRENAME_PARAMS_SVH
`define FXRENAME_PARAMS_SVH

// group shape
`define RAT_LANES 2
`define RAT_OPERANDS 3

// architectural fixed-point registers
`define RAT_REGS 32

// field widths
`define RAT_OPERAND_W 64
`define RAT_TAG_W 7  // reorder buffer entry
`define RAT_REG_W 5  // low bits of an operand
`define RAT_OPCODE_W 12

`endif

//--- verilog/ratDependencyCheck.sv
`include "fxRename_params.svh"

module ratDependencyCheck
(
    input  logic stageValid_i,
    input  logic [`RAT_LANES-1:0] laneLive_i,
    input  fxRenamePkg::robTag_t [`RAT_LANES-1:0] robEntry_i,
    input  fxRenamePkg::operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operand_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandEn_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandIsReg_i,
    input  fxRenamePkg::operandKind_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandKind_i,
    output fxRenamePkg::regIndex_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] readIndex_o,
    input  fxRenamePkg::robTag_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] readTag_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] readMapped_i,
    output logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] writeEn_o,
    output fxRenamePkg::regIndex_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] writeIndex_o,
    output fxRenamePkg::robTag_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] writeTag_o,
    output fxRenamePkg::operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] resolved_o,
    output logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] resolvedMapped_o
);
    import fxRenamePkg::*;

    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] isWrite;  // kind renames the register
    logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] fwdHit;
    robTag_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] fwdTag;

    always_comb
    begin
        for (int l = 0; l < `RAT_LANES; l++)
        begin
            for (int o = 0; o < `RAT_OPERANDS; o++)
            begin
                readIndex_o[l][o] = operand_i[l][o][`RAT_REG_W-1:0];
                isWrite[l][o] = operandKind_i[l][o] inside {kindWrite, kindReadWrite};
                writeEn_o[l][o] = stageValid_i && laneLive_i[l] && operandEn_i[l][o]
                    && operandIsReg_i[l][o] && isWrite[l][o];
                writeIndex_o[l][o] = readIndex_o[l][o];
                writeTag_o[l][o] = robEntry_i[l];  // lane's own entry
            end
        end
    end

    // same-group writes from earlier lanes, the latest earlier lane wins
    always_comb
    begin
        fwdHit = '0;
        fwdTag = '0;
        for (int l = 1; l < `RAT_LANES; l++)
        begin
            for (int o = 0; o < `RAT_OPERANDS; o++)
            begin
                for (int k = 0; k < l; k++)
                begin
                    for (int w = 0; w < `RAT_OPERANDS; w++)
                    begin
                        if (writeEn_o[k][w] && writeIndex_o[k][w] == readIndex_o[l][o])
                        begin
                            fwdHit[l][o] = 1'b1;
                            fwdTag[l][o] = writeTag_o[k][w];
                        end
                    end
                end
            end
        end
    end

    always_comb
    begin
        for (int l = 0; l < `RAT_LANES; l++)
        begin
            for (int o = 0; o < `RAT_OPERANDS; o++)
            begin
                resolved_o[l][o] = '0;  // disabled slots read as zero
                resolvedMapped_o[l][o] = 1'b0;
                if (operandEn_i[l][o])
                begin
                    if (!operandIsReg_i[l][o])
                        resolved_o[l][o] = operand_i[l][o];  // immediate
                    else if (fwdHit[l][o])
                    begin
                        resolved_o[l][o] = operand_t'(fwdTag[l][o]);
                        resolvedMapped_o[l][o] = 1'b1;
                    end
                    else if (readMapped_i[l][o])
                    begin
                        resolved_o[l][o] = operand_t'(readTag_i[l][o]);
                        resolvedMapped_o[l][o] = 1'b1;
                    end
                    else
                        resolved_o[l][o] = operand_t'(readIndex_o[l][o]);  // still architectural
                end
            end
        end
    end

    // a destination that is not a register would never be renamed
    always_comb
    begin
        for (int l = 0; l < `RAT_LANES; l++)
        begin
            for (int o = 0; o < `RAT_OPERANDS; o++)
            begin
                if (stageValid_i && laneLive_i[l] && operandEn_i[l][o] && isWrite[l][o])
                    assert (operandIsReg_i[l][o])
                    else $error("write operand lane %0d slot %0d is not a register", l, o);
            end
        end
    end

endmodule

//--- verilog/ratGroupLatch.sv
`include "fxRename_params.svh"

module ratGroupLatch
(
    input  logic clock_i,
    input  logic reset_i,
    input  logic enable_i,
    input  fxRenamePkg::laneCount_t numInst_i,
    input  fxRenamePkg::robTag_t [`RAT_LANES-1:0] robEntry_i,
    input  fxRenamePkg::opCode_t [`RAT_LANES-1:0] opCode_i,
    input  fxRenamePkg::operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operand_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandEn_i,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandIsReg_i,
    input  fxRenamePkg::operandKind_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandKind_i,
    output logic stageValid_o,
    output logic [`RAT_LANES-1:0] laneLive_o,
    output fxRenamePkg::laneCount_t numInst_o,
    output fxRenamePkg::robTag_t [`RAT_LANES-1:0] robEntry_o,
    output fxRenamePkg::opCode_t [`RAT_LANES-1:0] opCode_o,
    output fxRenamePkg::operand_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operand_o,
    output logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandEn_o,
    output logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandIsReg_o,
    output fxRenamePkg::operandKind_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] operandKind_o
);

    logic [`RAT_LANES-1:0] liveNext;  // lanes covered by the incoming count

    always_comb
    begin
        for (int l = 0; l < `RAT_LANES; l++)
            liveNext[l] = (l <= int'(numInst_i));
    end

    always_ff @(posedge clock_i)
    begin
        if (reset_i)
        begin
            stageValid_o <= 1'b0;
            laneLive_o <= '0;
        end
        else
        begin
            stageValid_o <= enable_i;  // single-cycle strobe, no stall
            if (enable_i)
                laneLive_o <= liveNext;
        end
    end

    // lanes past the count keep whatever they held before
    always_ff @(posedge clock_i)
    begin
        if (enable_i)
        begin
            numInst_o <= numInst_i;
            for (int l = 0; l < `RAT_LANES; l++)
            begin
                if (liveNext[l])
                begin
                    robEntry_o[l] <= robEntry_i[l];
                    opCode_o[l] <= opCode_i[l];
                    operand_o[l] <= operand_i[l];
                    operandEn_o[l] <= operandEn_i[l];
                    operandIsReg_o[l] <= operandIsReg_i[l];
                    operandKind_o[l] <= operandKind_i[l];
                end
            end
        end
    end

    // count stays inside the lane range
    laneCountInRange: assert property (@(posedge clock_i) disable iff (reset_i)
        enable_i |-> (int'(numInst_i) < `RAT_LANES))
        else $error("group count outside lane range");

endmodule

//--- verilog/ratMapTable.sv
`include "fxRename_params.svh"

module ratMapTable
(
    input  logic clock_i,
    input  logic reset_i,
    input  fxRenamePkg::regIndex_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] readIndex_i,
    output fxRenamePkg::robTag_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] readTag_o,
    output logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] readMapped_o,
    input  logic [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] writeEn_i,
    input  fxRenamePkg::regIndex_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] writeIndex_i,
    input  fxRenamePkg::robTag_t [`RAT_LANES-1:0][`RAT_OPERANDS-1:0] writeTag_i
);
    import fxRenamePkg::*;

    robTag_t tagTable [`RAT_REGS];  // latest in-flight writer per register
    logic [`RAT_REGS-1:0] mappedTable;

    // one read port per operand slot
    always_comb
    begin
        for (int l = 0; l < `RAT_LANES; l++)
        begin
            for (int o = 0; o < `RAT_OPERANDS; o++)
            begin
                readTag_o[l][o] = tagTable[readIndex_i[l][o]];
                readMapped_o[l][o] = mappedTable[readIndex_i[l][o]];
            end
        end
    end

    // later lanes and later operands overwrite earlier ones
    always_ff @(posedge clock_i)
    begin
        for (int l = 0; l < `RAT_LANES; l++)
        begin
            for (int o = 0; o < `RAT_OPERANDS; o++)
            begin
                if (writeEn_i[l][o])
                    tagTable[writeIndex_i[l][o]] <= writeTag_i[l][o];
            end
        end
    end

    always_ff @(posedge clock_i)
    begin
        if (reset_i)
            mappedTable <= '0;  // every register back to its architectural copy
        else
        begin
            for (int l = 0; l < `RAT_LANES; l++)
            begin
                for (int o = 0; o < `RAT_OPERANDS; o++)
                begin
                    if (writeEn_i[l][o])
                        mappedTable[writeIndex_i[l][o]] <= 1'b1;
                end
            end
        end
    end

endmodule
